//--- hw/id_pkg.sv
// RV64I subset only; no CSR, load/store or W ops, and opcode values are the standard encodings
package id_pkg;

  localparam int XLEN        = 64;
  localparam int INST_WD     = 32;
  localparam int GPR_ADDR_WD = 5;
  localparam int NUM_GPR     = 32;

  typedef enum logic [6:0] {
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011
  } opcode_e;

  typedef enum logic [3:0] {
    ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
    PASS_B // lui result
  } alu_op_e;

  // same values as funct3 of the branch group
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } br_func_e;

  typedef enum logic {RS1, PC} src1_sel_e;

  typedef enum logic [1:0] {RS2, IMM, FOUR} src2_sel_e;

  typedef struct packed {
    logic [INST_WD-1:0] inst;
    logic [XLEN-1:0]    pc;
  } fetch_bus_t;

  typedef struct packed {
    alu_op_e   alu_op;
    src1_sel_e src1_sel;
    src2_sel_e src2_sel;
    logic      gpr_wen;
    logic      bren;
    br_func_e  br_func;
    logic      is_jal;
    logic      is_jalr;
    logic      uses_rs1;
    logic      uses_rs2;
    logic      invalid;
  } ctrl_t;

  typedef struct packed {
    logic [XLEN-1:0]        rs1_data;
    logic [XLEN-1:0]        rs2_data;
    logic [XLEN-1:0]        imm;
    logic [XLEN-1:0]        pc;
    logic [GPR_ADDR_WD-1:0] rd;
    alu_op_e                alu_op;
    src1_sel_e              src1_sel;
    src2_sel_e              src2_sel;
    logic                   gpr_wen;
    logic                   invalid;
  } issue_bus_t;

  typedef struct packed {
    logic                   wen;
    logic [GPR_ADDR_WD-1:0] waddr;
    logic [XLEN-1:0]        wdata;
  } wb_bus_t;

  typedef struct packed {
    logic [GPR_ADDR_WD-1:0] es_rd;
    logic [GPR_ADDR_WD-1:0] ms_rd;
    logic [GPR_ADDR_WD-1:0] ws_rd;
  } hazard_rd_t;

  typedef struct packed {
    logic            taken;
    logic [XLEN-1:0] target;
  } redirect_t;

endpackage

//--- hw/fetch_latch.sv
// holds one instruction; the bus loads only when fetch valid meets allowin
`timescale 1ns/10ps

module fetch_latch
  import id_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst_n,
  input  logic       i_fs_to_ds_valid,
  input  fetch_bus_t i_fs_to_ds_bus,
  input  logic       i_ready_go,
  input  logic       i_es_allowin,
  output logic       o_ds_allowin,
  output logic       o_ds_valid,
  output fetch_bus_t o_fetch
);

  logic       ds_valid;
  fetch_bus_t fetch_q;

  // empty, or the held one leaves this cycle
  assign o_ds_allowin = !ds_valid || (i_ready_go && i_es_allowin);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ds_valid <= 1'b0;
      fetch_q  <= '0;
    end else begin
      if (o_ds_allowin) begin
        ds_valid <= i_fs_to_ds_valid;
      end
      if (i_fs_to_ds_valid && o_ds_allowin) begin
        fetch_q <= i_fs_to_ds_bus;
      end
    end
  end

  assign o_ds_valid = ds_valid;
  assign o_fetch    = fetch_q;

  // stalled instruction must not change under the decoder
  a_hold_stable: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    (ds_valid && !o_ds_allowin) |=> $stable(fetch_q));

endmodule

//--- hw/inst_decoder.sv
// OP, OP-IMM, LUI, AUIPC, JAL, JALR, branches; shift immediates carry the 6-bit shamt only
`timescale 1ns/10ps

module inst_decoder
  import id_pkg::*;
(
  input  logic [INST_WD-1:0]     i_inst,
  output ctrl_t                  o_ctrl,
  output logic [GPR_ADDR_WD-1:0] o_rs1,
  output logic [GPR_ADDR_WD-1:0] o_rs2,
  output logic [GPR_ADDR_WD-1:0] o_rd,
  output logic [XLEN-1:0]        o_imm
);

  opcode_e         opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] imm_sh;

  assign opcode = opcode_e'(i_inst[6:0]);
  assign funct3 = i_inst[14:12];
  assign funct7 = i_inst[31:25];

  assign o_rd  = i_inst[11:7];
  assign o_rs1 = i_inst[19:15];
  assign o_rs2 = i_inst[24:20];

  assign imm_i  = {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_u  = {{(XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_b  = {{(XLEN-12){i_inst[31]}}, i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_j  = {{(XLEN-20){i_inst[31]}}, i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};
  assign imm_sh = {{(XLEN-6){1'b0}}, i_inst[25:20]};

  // alt picks SUB for 000 and SRA for 101
  function automatic alu_op_e f3_to_alu(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? SUB : ADD;
      3'b001:  return SLL;
      3'b010:  return SLT;
      3'b011:  return SLTU;
      3'b100:  return XOR;
      3'b101:  return alt ? SRA : SRL;
      3'b110:  return OR;
      default: return AND;
    endcase
  endfunction

  always_comb begin
    o_ctrl          = '0;
    o_ctrl.alu_op   = ADD;
    o_ctrl.src1_sel = RS1;
    o_ctrl.src2_sel = RS2;
    o_ctrl.br_func  = br_func_e'(funct3);
    o_imm           = '0;
    case (opcode)
      OP_IMM: begin
        o_ctrl.alu_op   = f3_to_alu(funct3, (funct3 == 3'b101) && i_inst[30]);
        o_ctrl.src2_sel = IMM;
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.uses_rs1 = 1'b1;
        o_imm           = (funct3[1:0] == 2'b01) ? imm_sh : imm_i; // slli/srli/srai
      end
      OP: begin
        o_ctrl.alu_op   = f3_to_alu(funct3, funct7[5]);
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.uses_rs1 = 1'b1;
        o_ctrl.uses_rs2 = 1'b1;
        if (!(funct7 == 7'b0000000 ||
              (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)))) begin
          o_ctrl.invalid = 1'b1;
        end
      end
      LUI: begin
        o_ctrl.alu_op   = PASS_B;
        o_ctrl.src2_sel = IMM;
        o_ctrl.gpr_wen  = 1'b1;
        o_imm           = imm_u;
      end
      AUIPC: begin
        o_ctrl.src1_sel = PC;
        o_ctrl.src2_sel = IMM;
        o_ctrl.gpr_wen  = 1'b1;
        o_imm           = imm_u;
      end
      JAL: begin
        o_ctrl.src1_sel = PC; // link = pc + 4
        o_ctrl.src2_sel = FOUR;
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.is_jal   = 1'b1;
        o_imm           = imm_j;
      end
      JALR: begin
        o_ctrl.src1_sel = PC;
        o_ctrl.src2_sel = FOUR;
        o_ctrl.gpr_wen  = 1'b1;
        o_ctrl.is_jalr  = 1'b1;
        o_ctrl.uses_rs1 = 1'b1;
        o_imm           = imm_i;
      end
      BRANCH: begin
        o_ctrl.bren     = 1'b1;
        o_ctrl.uses_rs1 = 1'b1;
        o_ctrl.uses_rs2 = 1'b1;
        o_imm           = imm_b;
      end
      default: o_ctrl.invalid = 1'b1;
    endcase
    if (o_ctrl.invalid) begin
      o_ctrl.gpr_wen  = 1'b0;
      o_ctrl.bren     = 1'b0;
      o_ctrl.is_jal   = 1'b0;
      o_ctrl.is_jalr  = 1'b0;
      o_ctrl.uses_rs1 = 1'b0;
      o_ctrl.uses_rs2 = 1'b0;
    end
  end

endmodule

//--- hw/gpr_file.sv
// 32x64 registers, no write-to-read bypass; a write is visible from the next cycle on
`timescale 1ns/10ps

module gpr_file
  import id_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic [GPR_ADDR_WD-1:0] i_raddr1,
  input  logic [GPR_ADDR_WD-1:0] i_raddr2,
  output logic [XLEN-1:0]        o_rdata1,
  output logic [XLEN-1:0]        o_rdata2,
  input  wb_bus_t                i_wb
);

  logic [XLEN-1:0] regs [NUM_GPR];

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 0; i < NUM_GPR; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wb.wen && i_wb.waddr != '0) begin // x0 stays zero
      regs[i_wb.waddr] <= i_wb.wdata;
    end
  end

  assign o_rdata1 = regs[i_raddr1];
  assign o_rdata2 = regs[i_raddr2];

  // x0 holds zero across any writeback traffic
  a_x0_zero: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    regs[0] == '0);

endmodule

//--- hw/branch_unit.sv
// jalr target has bit 0 cleared; o_link is for checking, execute forms the link itself
`timescale 1ns/10ps

module branch_unit
  import id_pkg::*;
(
  input  ctrl_t           i_ctrl,
  input  logic [XLEN-1:0] i_rs1_data,
  input  logic [XLEN-1:0] i_rs2_data,
  input  logic [XLEN-1:0] i_pc,
  input  logic [XLEN-1:0] i_imm,
  output logic            o_taken,
  output logic [XLEN-1:0] o_target,
  output logic [XLEN-1:0] o_link
);

  logic            cond;
  logic [XLEN-1:0] jalr_sum;
  logic [XLEN-1:0] link_src1;
  logic [XLEN-1:0] link_src2;

  always_comb begin
    case (i_ctrl.br_func)
      BEQ:     cond = i_rs1_data == i_rs2_data;
      BNE:     cond = i_rs1_data != i_rs2_data;
      BLT:     cond = $signed(i_rs1_data) < $signed(i_rs2_data);
      BGE:     cond = $signed(i_rs1_data) >= $signed(i_rs2_data);
      BLTU:    cond = i_rs1_data < i_rs2_data;
      BGEU:    cond = i_rs1_data >= i_rs2_data;
      default: cond = 1'b0; // funct3 010/011
    endcase
  end

  assign jalr_sum = i_rs1_data + i_imm;

  assign o_taken  = (i_ctrl.bren && cond) || i_ctrl.is_jal || i_ctrl.is_jalr;
  assign o_target = i_ctrl.is_jalr ? {jalr_sum[XLEN-1:1], 1'b0} : i_pc + i_imm;
  assign o_link   = i_pc + XLEN'(4);

  // what execute will compute from the decoder's selects
  assign link_src1 = (i_ctrl.src1_sel == PC) ? i_pc : i_rs1_data;
  assign link_src2 = (i_ctrl.src2_sel == FOUR) ? XLEN'(4) : i_imm;

  always_comb begin
    if (i_ctrl.is_jal || i_ctrl.is_jalr) begin
      a_link_sel: assert (i_ctrl.alu_op == ADD && link_src1 + link_src2 == o_link);
    end
  end

endmodule

//--- hw/issue_ctrl.sv
// stalls on any nonzero later-stage rd matching a used source; no forwarding
`timescale 1ns/10ps

module issue_ctrl
  import id_pkg::*;
(
  input  logic                   i_ds_valid,
  input  ctrl_t                  i_ctrl,
  input  logic [GPR_ADDR_WD-1:0] i_rs1,
  input  logic [GPR_ADDR_WD-1:0] i_rs2,
  input  logic [GPR_ADDR_WD-1:0] i_rd,
  input  hazard_rd_t             i_hazard_rd,
  input  logic [XLEN-1:0]        i_rs1_data,
  input  logic [XLEN-1:0]        i_rs2_data,
  input  logic [XLEN-1:0]        i_imm,
  input  logic [XLEN-1:0]        i_pc,
  input  logic                   i_taken,
  input  logic [XLEN-1:0]        i_target,
  output logic                   o_ready_go,
  output logic                   o_ds_to_es_valid,
  output issue_bus_t             o_ds_to_es_bus,
  output redirect_t              o_redirect
);

  logic raw_stall;

  function automatic logic raw_hit(input logic [GPR_ADDR_WD-1:0] busy_rd);
    return (busy_rd != '0) &&
           ((i_ctrl.uses_rs1 && busy_rd == i_rs1) || (i_ctrl.uses_rs2 && busy_rd == i_rs2));
  endfunction

  assign raw_stall = raw_hit(i_hazard_rd.es_rd) || raw_hit(i_hazard_rd.ms_rd) ||
                     raw_hit(i_hazard_rd.ws_rd);

  assign o_ready_go       = !raw_stall;
  assign o_ds_to_es_valid = i_ds_valid && o_ready_go;

  assign o_ds_to_es_bus.rs1_data = i_rs1_data;
  assign o_ds_to_es_bus.rs2_data = i_rs2_data;
  assign o_ds_to_es_bus.imm      = i_imm;
  assign o_ds_to_es_bus.pc       = i_pc;
  assign o_ds_to_es_bus.rd       = i_rd;
  assign o_ds_to_es_bus.alu_op   = i_ctrl.alu_op;
  assign o_ds_to_es_bus.src1_sel = i_ctrl.src1_sel;
  assign o_ds_to_es_bus.src2_sel = i_ctrl.src2_sel;
  assign o_ds_to_es_bus.gpr_wen  = i_ctrl.gpr_wen;
  assign o_ds_to_es_bus.invalid  = i_ctrl.invalid;

  // held while execute back-pressures, fetch keeps steering
  assign o_redirect.taken  = o_ds_to_es_valid && i_taken;
  assign o_redirect.target = i_target;

  // decoder must have cleared jump/branch enables on an invalid opcode
  always_comb begin
    if (o_redirect.taken) begin
      a_redirect_issued: assert (o_ds_to_es_valid && !i_ctrl.invalid);
    end
  end

endmodule

//--- hw/id_stage.sv
// decode stage; fetch must drop its own wrong-path instruction when o_redirect.taken is high
`timescale 1ns/10ps

module id_stage
  import id_pkg::*;
(
  input  logic       i_clk,
  input  logic       i_rst_n,
  // from fetch
  input  logic       i_fs_to_ds_valid,
  input  fetch_bus_t i_fs_to_ds_bus,
  output logic       o_ds_allowin,
  // to execute
  input  logic       i_es_allowin,
  output logic       o_ds_to_es_valid,
  output issue_bus_t o_ds_to_es_bus,
  // from later stages
  input  wb_bus_t    i_wb,
  input  hazard_rd_t i_hazard_rd,
  output redirect_t  o_redirect
);

  logic                   ds_valid;
  fetch_bus_t             ds_fetch;
  logic                   ready_go;
  ctrl_t                  ctrl;
  logic [GPR_ADDR_WD-1:0] rs1;
  logic [GPR_ADDR_WD-1:0] rs2;
  logic [GPR_ADDR_WD-1:0] rd;
  logic [XLEN-1:0]        imm;
  logic [XLEN-1:0]        rs1_data;
  logic [XLEN-1:0]        rs2_data;
  logic                   br_taken;
  logic [XLEN-1:0]        br_target;

  fetch_latch u_fetch_latch (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_fs_to_ds_valid (i_fs_to_ds_valid),
    .i_fs_to_ds_bus   (i_fs_to_ds_bus),
    .i_ready_go       (ready_go),
    .i_es_allowin     (i_es_allowin),
    .o_ds_allowin     (o_ds_allowin),
    .o_ds_valid       (ds_valid),
    .o_fetch          (ds_fetch)
  );

  inst_decoder u_inst_decoder (
    .i_inst (ds_fetch.inst),
    .o_ctrl (ctrl),
    .o_rs1  (rs1),
    .o_rs2  (rs2),
    .o_rd   (rd),
    .o_imm  (imm)
  );

  gpr_file u_gpr_file (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .o_rdata1 (rs1_data),
    .o_rdata2 (rs2_data),
    .i_wb     (i_wb)
  );

  branch_unit u_branch_unit (
    .i_ctrl     (ctrl),
    .i_rs1_data (rs1_data),
    .i_rs2_data (rs2_data),
    .i_pc       (ds_fetch.pc),
    .i_imm      (imm),
    .o_taken    (br_taken),
    .o_target   (br_target),
    .o_link     () // execute rebuilds the link from pc and FOUR
  );

  issue_ctrl u_issue_ctrl (
    .i_ds_valid       (ds_valid),
    .i_ctrl           (ctrl),
    .i_rs1            (rs1),
    .i_rs2            (rs2),
    .i_rd             (rd),
    .i_hazard_rd      (i_hazard_rd),
    .i_rs1_data       (rs1_data),
    .i_rs2_data       (rs2_data),
    .i_imm            (imm),
    .i_pc             (ds_fetch.pc),
    .i_taken          (br_taken),
    .i_target         (br_target),
    .o_ready_go       (ready_go),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_ds_to_es_bus   (o_ds_to_es_bus),
    .o_redirect       (o_redirect)
  );

endmodule

//--- bench/tb_encode.svh
// RV64I encoders for the testbench plus xorshift32; branch and jump offsets must be even
`ifndef TB_ENCODE_SVH
`define TB_ENCODE_SVH

function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd, input logic [6:0] opc);
  return {f7, rs2, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] opc);
  return {imm, rs1, f3, rd, opc};
endfunction

function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                      input logic [6:0] opc);
  return {imm, rd, opc};
endfunction

// bit 0 of the offset is dropped
function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
endfunction

`endif

//--- bench/tb_id_stage.sv
// one instruction in flight at a time; no writeback traffic while an instruction is held
`timescale 1ns/10ps

module tb_id_stage
  import id_pkg::*;
();

  logic       clk;
  logic       rst_n;
  logic       fs_valid;
  fetch_bus_t fs_bus;
  logic       ds_allowin;
  logic       es_allowin;
  logic       ds_to_es_valid;
  issue_bus_t ds_bus;
  wb_bus_t    wb;
  hazard_rd_t hz;
  redirect_t  redirect;

  int          err_cnt = 0;
  int          timeout_cnt = 0;
  int          sent_cnt = 0;
  int          leave_cnt = 0;
  logic [31:0] rng;
  logic [63:0] next_pc;
  logic [63:0] shadow [NUM_GPR];
  issue_bus_t  exp_bus;
  logic        exp_taken;
  logic [63:0] exp_target;
  logic        exp_use1;
  logic        exp_use2;
  logic [4:0]  exp_rs1;
  logic [4:0]  exp_rs2;
  logic        exp_stall;
  logic        accepted; // instruction sits in the stage

  `include "tb_encode.svh"

  id_stage DUT (
    .i_clk            (clk),
    .i_rst_n          (rst_n),
    .i_fs_to_ds_valid (fs_valid),
    .i_fs_to_ds_bus   (fs_bus),
    .o_ds_allowin     (ds_allowin),
    .i_es_allowin     (es_allowin),
    .o_ds_to_es_valid (ds_to_es_valid),
    .o_ds_to_es_bus   (ds_bus),
    .i_wb             (wb),
    .i_hazard_rd      (hz),
    .o_redirect       (redirect)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always_comb begin
    exp_stall = 1'b0;
    for (int k = 0; k < 3; k++) begin
      logic [4:0] r;
      r = hz[k*5 +: 5];
      if (r != 5'd0 && ((exp_use1 && r == exp_rs1) || (exp_use2 && r == exp_rs2))) begin
        exp_stall = 1'b1;
      end
    end
  end

  always @(posedge clk) begin
    if (rst_n && ds_to_es_valid && es_allowin) leave_cnt <= leave_cnt + 1;
  end

  task automatic report_mismatch(input string msg);
    err_cnt++;
    $display("MISMATCH %0t: %s", $time, msg);
  endtask

  a_decode: assert property (@(posedge clk) disable iff (!rst_n) ds_to_es_valid |->
    ds_bus.pc == exp_bus.pc && ds_bus.rd == exp_bus.rd && ds_bus.gpr_wen == exp_bus.gpr_wen &&
    ds_bus.invalid == exp_bus.invalid && (exp_bus.invalid || (ds_bus.alu_op == exp_bus.alu_op &&
    ds_bus.src1_sel == exp_bus.src1_sel && ds_bus.src2_sel == exp_bus.src2_sel &&
    ds_bus.imm == exp_bus.imm)))
    else report_mismatch("decoded fields differ from reference");
  a_operands: assert property (@(posedge clk) disable iff (!rst_n) ds_to_es_valid |->
    ds_bus.rs1_data == exp_bus.rs1_data && ds_bus.rs2_data == exp_bus.rs2_data)
    else report_mismatch("operand data differs from shadow registers");
  a_redirect: assert property (@(posedge clk) disable iff (!rst_n) ds_to_es_valid |->
    redirect.taken == exp_taken && (!exp_taken || redirect.target == exp_target))
    else report_mismatch("redirect taken or target wrong");
  a_quiet: assert property (@(posedge clk) disable iff (!rst_n)
    !ds_to_es_valid |-> !redirect.taken)
    else report_mismatch("redirect without issue");
  a_stall: assert property (@(posedge clk) disable iff (!rst_n) exp_stall |-> !ds_to_es_valid)
    else report_mismatch("issued across a hazard");
  a_go: assert property (@(posedge clk) disable iff (!rst_n)
    (accepted && !exp_stall) |-> ds_to_es_valid)
    else report_mismatch("stalled with no hazard");
  a_no_dup: assert property (@(posedge clk) disable iff (!rst_n) !accepted |-> !ds_to_es_valid)
    else report_mismatch("issue with no instruction held");
  a_bp_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (ds_to_es_valid && !es_allowin) |=> $stable(ds_bus))
    else report_mismatch("bus moved under back-pressure");
  a_bp_allowin: assert property (@(posedge clk) disable iff (!rst_n)
    (accepted && !es_allowin) |-> !ds_allowin)
    else report_mismatch("allowin high under back-pressure");

  function automatic logic [31:0] rand32();
    rng = xorshift32(rng);
    return rng;
  endfunction

  function automatic alu_op_e alu_for(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0:    return alt ? SUB : ADD;
      3'd1:    return SLL;
      3'd2:    return SLT;
      3'd3:    return SLTU;
      3'd4:    return XOR;
      3'd5:    return alt ? SRA : SRL;
      3'd6:    return OR;
      default: return AND;
    endcase
  endfunction

  function automatic logic branch_cond(input logic [2:0] f3, input logic [63:0] a,
                                       input logic [63:0] b);
    case (f3)
      3'd0:    return a == b;
      3'd1:    return a != b;
      3'd4:    return $signed(a) < $signed(b);
      3'd5:    return $signed(a) >= $signed(b);
      3'd6:    return a < b;
      default: return a >= b;
    endcase
  endfunction

  // reference decode straight from the RV64I encoding
  task automatic build_expect(input logic [31:0] inst, input logic [63:0] pc);
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [63:0] imm_i;
    logic [63:0] imm_u;
    f3 = inst[14:12];
    f7 = inst[31:25];
    imm_i = {{52{inst[31]}}, inst[31:20]};
    imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
    exp_bus = '0;
    exp_bus.pc = pc;
    exp_bus.rd = inst[11:7];
    exp_rs1 = inst[19:15];
    exp_rs2 = inst[24:20];
    exp_bus.rs1_data = shadow[exp_rs1];
    exp_bus.rs2_data = shadow[exp_rs2];
    exp_bus.alu_op = ADD;
    exp_bus.src1_sel = RS1;
    exp_bus.src2_sel = RS2;
    exp_use1 = 1'b0;
    exp_use2 = 1'b0;
    exp_taken = 1'b0;
    exp_target = '0;
    case (inst[6:0])
      7'b0010011: begin
        exp_bus.alu_op = alu_for(f3, f3 == 3'd5 && inst[30]);
        exp_bus.src2_sel = IMM;
        exp_bus.imm = (f3 == 3'd1 || f3 == 3'd5) ? {58'd0, inst[25:20]} : imm_i;
        exp_bus.gpr_wen = 1'b1;
        exp_use1 = 1'b1;
      end
      7'b0110011: begin
        exp_bus.invalid = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
        exp_bus.alu_op = alu_for(f3, f7[5]);
        exp_bus.gpr_wen = !exp_bus.invalid;
        exp_use1 = !exp_bus.invalid;
        exp_use2 = !exp_bus.invalid;
      end
      7'b0110111, 7'b0010111: begin // lui, auipc
        exp_bus.alu_op = inst[5] ? PASS_B : ADD;
        exp_bus.src1_sel = inst[5] ? RS1 : PC;
        exp_bus.src2_sel = IMM;
        exp_bus.imm = imm_u;
        exp_bus.gpr_wen = 1'b1;
      end
      7'b1101111, 7'b1100111: begin // jal, jalr
        exp_bus.src1_sel = PC;
        exp_bus.src2_sel = FOUR;
        exp_bus.gpr_wen = 1'b1;
        exp_taken = 1'b1;
        exp_use1 = !inst[3];
        exp_bus.imm = inst[3] ?
          {{44{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0} : imm_i;
        exp_target = inst[3] ? pc + exp_bus.imm : (exp_bus.rs1_data + imm_i) & ~64'd1;
      end
      7'b1100011: begin
        exp_bus.imm = {{52{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        exp_use1 = 1'b1;
        exp_use2 = 1'b1;
        exp_taken = branch_cond(f3, exp_bus.rs1_data, exp_bus.rs2_data);
        exp_target = pc + exp_bus.imm;
      end
      default: exp_bus.invalid = 1'b1;
    endcase
  endtask

  task automatic write_reg(input logic [4:0] addr, input logic [63:0] data);
    @(negedge clk);
    wb = '{wen: 1'b1, waddr: addr, wdata: data};
    if (addr != 5'd0) shadow[addr] = data;
    @(negedge clk);
    wb.wen = 1'b0;
  endtask

  // hazard released after hz_cycles, execute stalls for bp_cycles
  task automatic send_inst(input logic [31:0] inst, input hazard_rd_t hz_in,
                           input int hz_cycles, input int bp_cycles);
    int  n;
    logic done;
    @(negedge clk);
    build_expect(inst, next_pc);
    fs_valid = 1'b1;
    fs_bus = '{inst: inst, pc: next_pc};
    n = 0;
    #1;
    while (!ds_allowin && n <= 50) begin
      @(negedge clk);
      n++;
    end
    if (n > 50) begin
      timeout_cnt++;
      $display("timeout: the stage never accepted the instruction");
    end
    @(negedge clk);
    fs_valid = 1'b0;
    accepted = 1'b1;
    sent_cnt++;
    next_pc = next_pc + 64'd4;
    hz = hz_in;
    n = 0;
    done = 1'b0;
    while (!done) begin
      if (n >= hz_cycles) hz = '0;
      es_allowin = n >= bp_cycles;
      #1;
      if (ds_to_es_valid && es_allowin) begin
        done = 1'b1;
      end else if (n > 100) begin
        timeout_cnt++;
        $display("timeout: the held instruction never issued");
        done = 1'b1;
      end else begin
        @(negedge clk);
        n++;
      end
    end
    @(negedge clk);
    accepted = 1'b0;
    hz = '0;
    es_allowin = 1'b1;
  endtask

  function automatic logic [31:0] rand_alu_inst();
    logic [31:0] v;
    logic [31:0] w;
    logic [11:0] imm;
    v = rand32();
    w = rand32();
    imm = w[11:0];
    if (v[14:12] == 3'd1) imm = {6'd0, w[5:0]};
    if (v[14:12] == 3'd5) imm = {1'b0, w[6], 4'd0, w[5:0]}; // srli or srai
    case (v[31:30])
      2'd0: return enc_r({1'b0, v[29] && (v[14:12] == 3'd0 || v[14:12] == 3'd5), 5'd0},
                         v[24:20], v[19:15], v[14:12], v[11:7], OP);
      2'd1: return enc_i(imm, v[19:15], v[14:12], v[11:7], OP_IMM);
      2'd2: return enc_u(w[31:12], v[11:7], LUI);
      default: return enc_u(w[31:12], v[11:7], AUIPC);
    endcase
  endfunction

  initial begin
    logic [31:0] v;
    logic [31:0] w;
    logic [2:0]  f3;
    fs_valid = 1'b0;
    fs_bus = '0;
    es_allowin = 1'b1;
    wb = '0;
    hz = '0;
    accepted = 1'b0;
    rng = 32'h78ef;
    next_pc = 64'h8000_0000;
    for (int i = 0; i < NUM_GPR; i++) shadow[i] = '0;
    build_expect(32'd0, 64'd0);
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    a_reset: assert (ds_allowin && !ds_to_es_valid && !redirect.taken)
      else report_mismatch("outputs wrong after reset");
    for (int r = 1; r < NUM_GPR; r++) write_reg(5'(r), {rand32(), rand32()});
    write_reg(5'd0, 64'hffff_0000_ffff_0000); // must be dropped
    repeat (40) send_inst(rand_alu_inst(), '0, 0, 0);
    write_reg(5'd3, {rand32(), rand32()});
    send_inst(enc_r(7'h00, 5'd3, 5'd0, 3'd0, 5'd10, OP), '0, 0, 0);
    send_inst(enc_r(7'h00, 5'd6, 5'd5, 3'd0, 5'd7, OP), '{5'd5, 5'd0, 5'd0}, 3, 0);
    send_inst(enc_r(7'h20, 5'd6, 5'd5, 3'd0, 5'd7, OP), '{5'd0, 5'd6, 5'd0}, 2, 0);
    send_inst(enc_i(12'h009, 5'd4, 3'd0, 5'd8, OP_IMM), '{5'd0, 5'd0, 5'd4}, 4, 2);
    send_inst(enc_i(12'h009, 5'd4, 3'd0, 5'd8, OP_IMM), '{5'd9, 5'd0, 5'd0}, 3, 0);
    send_inst(enc_r(7'h00, 5'd0, 5'd0, 3'd6, 5'd1, OP), '{5'd0, 5'd0, 5'd0}, 3, 0);
    repeat (8) begin
      v = rand32();
      send_inst(rand_alu_inst(), '0, 0, 1 + int'(v[1:0]));
    end
    repeat (30) begin
      v = rand32();
      w = rand32();
      f3 = (v[2:1] == 2'd0) ? {2'b00, v[0]} : {1'b1, v[1], v[0]};
      send_inst(enc_b({w[12:1], 1'b0}, v[3] ? v[19:15] : v[24:20], v[19:15], f3),
                '0, 0, int'(v[5:4]));
    end
    repeat (4) begin
      v = rand32();
      send_inst(enc_j({v[20:1], 1'b0}, v[25:21]), '0, 0, 2);
      send_inst(enc_i(v[31:20], v[19:15], 3'd0, v[11:7], JALR), '0, 0, int'(v[1:0]));
    end
    send_inst(enc_i(12'h010, 5'd2, 3'd3, 5'd5, 7'b0000011), '0, 0, 1);
    send_inst(enc_r(7'h01, 5'd2, 5'd1, 3'd0, 5'd5, OP), '0, 0, 0);
    repeat (3) @(negedge clk);
    a_count: assert (leave_cnt == sent_cnt)
      else report_mismatch("issued count differs from accepted count");
    $display("checks done: %0d mismatches, %0d timeouts", err_cnt, timeout_cnt);
    if (err_cnt == 0 && timeout_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- flist.f
+incdir+bench
hw/id_pkg.sv
hw/fetch_latch.sv
hw/inst_decoder.sv
hw/gpr_file.sv
hw/branch_unit.sv
hw/issue_ctrl.sv
hw/id_stage.sv
bench/tb_id_stage.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -sv -f flist.f \
  --top-module tb_id_stage -Mdir obj_dir -o sim_id_stage

./obj_dir/sim_id_stage > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with errors" sim.log; then
  exit 1
fi
grep -q "Finished with no errors" sim.log
